/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_i2s_tx
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/i2s_pkg.sv
rtl/i2s_wb_regs.sv
rtl/i2s_clkgen.sv
rtl/i2s_sync_fifo.sv
rtl/i2s_serializer.sv
rtl/i2s_irq_ctrl.sv
rtl/i2s_tx_top.sv
verification/tb_i2s_tx.sv

/* rtl/i2s_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_clkgen
    import i2s_pkg::*;
(
    input  wire logic      wb_clk_i,
    input  wire logic      wb_rst_i,
    input  wire i2s_ctrl_t ctrl_i,
    output i2s_clk_t       clk_o
);

    logic [7:0] half_cnt;
    logic [5:0] bit_cnt;
    logic       sck_q;
    logic       ws_q;
    logic       half_done;
    logic       fall;

    assign half_done = (half_cnt == ctrl_i.ratio - 8'd1);
    // High in the cycle whose closing edge drops SCK
    assign fall      = ctrl_i.en & half_done & sck_q;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            half_cnt <= '0;
            bit_cnt  <= '0;
            sck_q    <= 1'b0;
            ws_q     <= 1'b0;
        end else if (!ctrl_i.en) begin
            half_cnt <= '0;
            bit_cnt  <= '0;
            sck_q    <= 1'b0;
            ws_q     <= 1'b0;
        end else begin
            if (half_done) begin
                half_cnt <= '0;
                sck_q    <= ~sck_q;
            end else begin
                half_cnt <= half_cnt + 8'd1;
            end
            // WS flips on the last falling edge of a slot
            if (fall) begin
                if (bit_cnt == ctrl_i.resolution - 6'd1) begin
                    bit_cnt <= '0;
                    ws_q    <= ~ws_q;
                end else begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
            end
        end
    end

    assign clk_o = '{sck: sck_q, ws: ws_q, shift: fall};

    a_ratio_nonzero: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        ctrl_i.en |-> (ctrl_i.ratio != 8'd0)
    );

endmodule

`default_nettype wire

/* rtl/i2s_irq_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_irq_ctrl
    import i2s_pkg::*;
#(
    parameter int FIFO_DEPTH = I2S_FIFO_DEPTH
) (
    input  wire logic                               wb_clk_i,
    input  wire logic                               wb_rst_i,
    input  wire logic                               int_en_i,
    input  wire i2s_irq_t                           mask_i,
    input  wire i2s_irq_t                           clr_i,
    input  wire logic                               empty_i,
    input  wire logic [$clog2(FIFO_DEPTH + 1)-1:0]  level_i,
    output i2s_irq_t                                stat_o,
    output logic                                    irq_o
);

    localparam int LW = $clog2(FIFO_DEPTH + 1);

    i2s_irq_t cond;
    i2s_irq_t cond_d;
    i2s_irq_t rise;

    assign cond.half  = (level_i <= LW'(FIFO_DEPTH / 2));
    assign cond.empty = empty_i;
    assign rise       = i2s_irq_t'(cond & ~cond_d);

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            cond_d <= '0;
            stat_o <= '0;
        end else begin
            cond_d <= cond;
            // Set has priority over a clear in the same cycle
            stat_o <= i2s_irq_t'((stat_o & ~clr_i) | (int_en_i ? rise : 2'b00));
        end
    end

    assign irq_o = |(stat_o & mask_i);

endmodule

`default_nettype wire

/* rtl/i2s_pkg.sv */
`default_nettype none

package i2s_pkg;

    // ==================================================
    // Defaults
    // ==================================================
    localparam int I2S_DATA_W     = 32;
    localparam int I2S_FIFO_DEPTH = 8;

    // Register byte offsets
    localparam logic [4:0] REG_CTRL    = 5'h00;
    localparam logic [4:0] REG_INTMASK = 5'h04;
    localparam logic [4:0] REG_INTSTAT = 5'h08;
    localparam logic [4:0] REG_TXDATA  = 5'h0C;
    localparam logic [4:0] REG_STATUS  = 5'h10;

    // ==================================================
    // Types
    // ==================================================

    // en ends up at bit 0
    typedef struct packed {
        logic [7:0] ratio;
        logic [5:0] resolution;
        logic       int_en;
        logic       lswap;
        logic       en;
    } i2s_ctrl_t;

    // Mask, status, clear and condition bits
    typedef struct packed {
        logic empty;
        logic half;
    } i2s_irq_t;

    typedef struct packed {
        logic sck;
        logic ws;
        logic shift;
    } i2s_clk_t;

endpackage

`default_nettype wire

/* rtl/i2s_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_serializer
    import i2s_pkg::*;
#(
    parameter int DATA_W = I2S_DATA_W
) (
    input  wire logic              wb_clk_i,
    input  wire logic              wb_rst_i,
    input  wire i2s_ctrl_t         ctrl_i,
    input  wire i2s_clk_t          clk_i,
    input  wire logic [DATA_W-1:0] rd_data_i,
    input  wire logic              empty_i,
    output logic                   pop_o,
    output logic                   sd_o
);

    localparam int IDX_W = $clog2(DATA_W);

    logic [DATA_W-1:0] shreg;
    logic [IDX_W-1:0]  bit_cnt;
    logic [IDX_W-1:0]  msb_idx;
    logic              ws_prev;
    logic              primed;
    logic              started;
    logic              sd_q;
    logic              slot_start;
    logic              left_slot;
    logic              take;

    assign msb_idx    = IDX_W'(ctrl_i.resolution - 6'd1);
    // WS edge seen one SCK late gives the one-bit delay
    assign slot_start = clk_i.shift & (~primed | (clk_i.ws != ws_prev));
    assign left_slot  = (clk_i.ws == ctrl_i.lswap);
    // First word after enable waits for a left slot
    assign take       = slot_start & ~empty_i & (started | left_slot);
    assign pop_o      = take;
    assign sd_o       = sd_q;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            ws_prev <= 1'b0;
            primed  <= 1'b0;
            started <= 1'b0;
            bit_cnt <= '0;
            sd_q    <= 1'b0;
        end else if (!ctrl_i.en) begin
            ws_prev <= 1'b0;
            primed  <= 1'b0;
            started <= 1'b0;
            bit_cnt <= '0;
            sd_q    <= 1'b0;
        end else if (clk_i.shift) begin
            primed  <= 1'b1;
            ws_prev <= clk_i.ws;
            if (slot_start) begin
                started <= started | take;
                bit_cnt <= msb_idx - 1'b1;
                sd_q    <= take ? rd_data_i[msb_idx] : 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
                sd_q    <= shreg[bit_cnt];
            end
        end
    end

    // Zeros stand in for a missing word
    always_ff @(posedge wb_clk_i) begin
        if (slot_start) begin
            shreg <= take ? rd_data_i : '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/i2s_sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_sync_fifo
    import i2s_pkg::*;
#(
    parameter int DATA_W     = I2S_DATA_W,
    parameter int FIFO_DEPTH = I2S_FIFO_DEPTH
) (
    input  wire logic                               wb_clk_i,
    input  wire logic                               wb_rst_i,
    input  wire logic                               push_i,
    input  wire logic [DATA_W-1:0]                  push_data_i,
    input  wire logic                               pop_i,
    output logic      [DATA_W-1:0]                  rd_data_o,
    output logic                                    full_o,
    output logic                                    empty_o,
    output logic      [$clog2(FIFO_DEPTH + 1)-1:0]  level_o
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int LW = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [LW-1:0]     level_q;
    logic              do_push;
    logic              do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push   = push_i & ~full_o;
    assign do_pop    = pop_i & ~empty_o;
    assign full_o    = (level_q == LW'(FIFO_DEPTH));
    assign empty_o   = (level_q == '0);
    assign level_o   = level_q;
    // Head word shows without a read request
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                level_q <= level_q + 1'b1;
            end else if (do_pop && !do_push) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    a_no_push_full: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i) push_i |-> !full_o
    );

    a_no_pop_empty: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i) pop_i |-> !empty_o
    );

endmodule

`default_nettype wire

/* rtl/i2s_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_tx_top
    import i2s_pkg::*;
#(
    parameter int DATA_W     = I2S_DATA_W,
    parameter int FIFO_DEPTH = I2S_FIFO_DEPTH
) (
    input  wire logic              wb_clk_i,
    input  wire logic              wb_rst_i,
    input  wire logic              wb_cyc_i,
    input  wire logic              wb_stb_i,
    input  wire logic              wb_we_i,
    input  wire logic [4:0]        wb_adr_i,
    input  wire logic [DATA_W-1:0] wb_dat_i,
    output logic      [DATA_W-1:0] wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   i2s_sck_o,
    output logic                   i2s_ws_o,
    output logic                   i2s_sd_o,
    output logic                   irq_o
);

    localparam int LW = $clog2(FIFO_DEPTH + 1);

    i2s_ctrl_t         ctrl;
    i2s_irq_t          irq_mask;
    i2s_irq_t          irq_clr;
    i2s_irq_t          irq_stat;
    i2s_clk_t          i2s_clk;
    logic              push;
    logic [DATA_W-1:0] push_data;
    logic              pop;
    logic [DATA_W-1:0] rd_data;
    logic              fifo_full;
    logic              fifo_empty;
    logic [LW-1:0]     fifo_level;

    i2s_wb_regs #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_regs (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .ctrl_o       (ctrl),
        .irq_mask_o   (irq_mask),
        .irq_clr_o    (irq_clr),
        .irq_stat_i   (irq_stat),
        .fifo_full_i  (fifo_full),
        .fifo_level_i (fifo_level),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    i2s_clkgen u_clkgen (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .ctrl_i   (ctrl),
        .clk_o    (i2s_clk)
    );

    i2s_sync_fifo #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .rd_data_o   (rd_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .level_o     (fifo_level)
    );

    i2s_serializer #(
        .DATA_W (DATA_W)
    ) u_ser (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .ctrl_i    (ctrl),
        .clk_i     (i2s_clk),
        .rd_data_i (rd_data),
        .empty_i   (fifo_empty),
        .pop_o     (pop),
        .sd_o      (i2s_sd_o)
    );

    i2s_irq_ctrl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_irq (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .int_en_i (ctrl.int_en),
        .mask_i   (irq_mask),
        .clr_i    (irq_clr),
        .empty_i  (fifo_empty),
        .level_i  (fifo_level),
        .stat_o   (irq_stat),
        .irq_o    (irq_o)
    );

    assign i2s_sck_o = i2s_clk.sck;
    assign i2s_ws_o  = i2s_clk.ws;

endmodule

`default_nettype wire

/* rtl/i2s_wb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module i2s_wb_regs
    import i2s_pkg::*;
#(
    parameter int DATA_W     = I2S_DATA_W,
    parameter int FIFO_DEPTH = I2S_FIFO_DEPTH
) (
    input  wire logic                               wb_clk_i,
    input  wire logic                               wb_rst_i,
    input  wire logic                               wb_cyc_i,
    input  wire logic                               wb_stb_i,
    input  wire logic                               wb_we_i,
    input  wire logic [4:0]                         wb_adr_i,
    input  wire logic [DATA_W-1:0]                  wb_dat_i,
    output logic      [DATA_W-1:0]                  wb_dat_o,
    output logic                                    wb_ack_o,
    output i2s_ctrl_t                               ctrl_o,
    output i2s_irq_t                                irq_mask_o,
    output i2s_irq_t                                irq_clr_o,
    input  wire i2s_irq_t                           irq_stat_i,
    input  wire logic                               fifo_full_i,
    input  wire logic [$clog2(FIFO_DEPTH + 1)-1:0]  fifo_level_i,
    output logic                                    push_o,
    output logic      [DATA_W-1:0]                  push_data_o
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

    i2s_ctrl_t         ctrl_q;
    i2s_irq_t          mask_q;
    logic              req;
    logic              wr_cyc;
    logic              rd_cyc;
    logic              tx_wr;
    logic              tx_stall;
    logic [DATA_W-1:0] rd_word;

    // No new request in the ack cycle
    assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr_cyc   = req & wb_we_i;
    assign rd_cyc   = req & ~wb_we_i;
    assign tx_wr    = wr_cyc & (wb_adr_i == REG_TXDATA);
    // Wait states until the FIFO has room
    assign tx_stall = tx_wr & fifo_full_i;

    assign push_o      = tx_wr & ~fifo_full_i;
    assign push_data_o = wb_dat_i;
    assign irq_clr_o   = (wr_cyc && wb_adr_i == REG_INTSTAT) ?
                         i2s_irq_t'(wb_dat_i[1:0]) : i2s_irq_t'(2'b00);

    assign ctrl_o     = ctrl_q;
    assign irq_mask_o = mask_q;

    always_comb begin
        rd_word = '0;
        case (wb_adr_i)
            REG_CTRL: begin
                rd_word[0]     = ctrl_q.en;
                rd_word[1]     = ctrl_q.lswap;
                rd_word[2]     = ctrl_q.int_en;
                rd_word[13:8]  = ctrl_q.resolution;
                rd_word[23:16] = ctrl_q.ratio;
            end
            REG_INTMASK: rd_word[1:0] = mask_q;
            REG_INTSTAT: rd_word[1:0] = irq_stat_i;
            REG_STATUS: begin
                rd_word[0]             = (fifo_level_i == '0);
                rd_word[1]             = fifo_full_i;
                rd_word[8 +: LEVEL_W]  = fifo_level_i;
            end
            default: ;
        endcase
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            ctrl_q   <= '0;
            mask_q   <= '0;
        end else begin
            wb_ack_o <= req & ~tx_stall;
            if (rd_cyc) begin
                wb_dat_o <= rd_word;
            end
            if (wr_cyc && wb_adr_i == REG_CTRL) begin
                ctrl_q.en         <= wb_dat_i[0];
                ctrl_q.lswap      <= wb_dat_i[1];
                ctrl_q.int_en     <= wb_dat_i[2];
                ctrl_q.resolution <= wb_dat_i[13:8];
                ctrl_q.ratio      <= wb_dat_i[23:16];
            end
            if (wr_cyc && wb_adr_i == REG_INTMASK) begin
                mask_q <= i2s_irq_t'(wb_dat_i[1:0]);
            end
        end
    end

    // The acked request is still held by the master
    a_ack_after_req: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i))
    );

endmodule

`default_nettype wire

/* verification/tb_i2s_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_i2s_tx
    import i2s_pkg::*;
();

    localparam int DATA_W     = I2S_DATA_W;
    localparam int FIFO_DEPTH = I2S_FIFO_DEPTH;
    localparam int RATIO      = 2;
    localparam int RES        = 16;
    localparam int N_MAIN     = 20;
    localparam int N_SWAP     = 6;
    localparam int TIMEOUT    = (N_MAIN + N_SWAP) * 2 * RES * 2 * RATIO + 2000;

    logic              wb_clk_i;
    logic              wb_rst_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [4:0]        wb_adr_i;
    logic [DATA_W-1:0] wb_dat_i;
    logic [DATA_W-1:0] wb_dat_o;
    logic              wb_ack_o;
    logic              i2s_sck_o;
    logic              i2s_ws_o;
    logic              i2s_sd_o;
    logic              irq_o;

    int                errors    = 0;
    int                cycles    = 0;
    int                seed      = 62;
    int                rx_total  = 0;
    int                ack_wait  = 0;
    logic [15:0]       exp_q [$];
    logic              cfg_lswap = 1'b0;
    logic              shape_on  = 1'b0;
    logic              rx_on     = 1'b0;
    logic              stall_probe = 1'b0;
    logic              sck_q     = 1'b0;
    logic              ws_q      = 1'b0;
    int                sck_run   = 0;
    int                sck_edges = 0;
    int                ws_rises  = 0;
    logic [15:0]       rx_sh     = '0;
    logic              rx_ws_prev = 1'b0;
    logic              rx_started = 1'b0;
    int                rx_idx    = 0;
    logic [DATA_W-1:0] rd_val;
    logic [15:0]       held_word;
    logic              sck_chg;
    logic              sck_rise;
    logic              sck_fall;
    logic              ws_chg;

    i2s_tx_top #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .i2s_sck_o (i2s_sck_o),
        .i2s_ws_o  (i2s_ws_o),
        .i2s_sd_o  (i2s_sd_o),
        .irq_o     (irq_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #2 wb_clk_i = ~wb_clk_i;
    end

    // ==================================================
    // Bus tasks and helpers
    // ==================================================
    task automatic write_reg(input logic [4:0] adr, input logic [DATA_W-1:0] dat);
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        ack_wait = 0;
        do begin
            @(posedge wb_clk_i);
            ack_wait++;
        end while (!wb_ack_o);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] adr, output logic [DATA_W-1:0] data);
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        do begin
            @(posedge wb_clk_i);
        end while (!wb_ack_o);
        data = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
    endtask

    task automatic compare_value(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic send_word(input logic [15:0] w);
        write_reg(REG_TXDATA, DATA_W'(w));
        exp_q.push_back(w);
    endtask

    function automatic logic [15:0] draw_word();
        return 16'($random(seed));
    endfunction

    // Field layout of CTRL
    function automatic logic [DATA_W-1:0] ctrl_value(input logic en, input logic lswap,
                                                     input logic int_en);
        logic [DATA_W-1:0] v;
        v        = '0;
        v[0]     = en;
        v[1]     = lswap;
        v[2]     = int_en;
        v[13:8]  = 6'(RES);
        v[23:16] = 8'(RATIO);
        return v;
    endfunction

    // ==================================================
    // Serial line monitors
    // ==================================================
    assign sck_chg  = (i2s_sck_o != sck_q);
    assign sck_rise = i2s_sck_o & ~sck_q;
    assign sck_fall = ~i2s_sck_o & sck_q;
    assign ws_chg   = (i2s_ws_o != ws_q);

    always @(posedge wb_clk_i) begin
        sck_q <= i2s_sck_o;
        ws_q  <= i2s_ws_o;
        if (!shape_on) begin
            sck_run   <= 0;
            sck_edges <= 0;
            ws_rises  <= 0;
        end else begin
            if (sck_chg) begin
                sck_run   <= 1;
                sck_edges <= sck_edges + 1;
            end else begin
                sck_run <= sck_run + 1;
            end
            if (ws_chg) begin
                ws_rises <= 0;
            end else if (sck_rise) begin
                ws_rises <= ws_rises + 1;
            end
        end
    end

    // A WS change on a rising edge closes the slot with the current bit
    always @(posedge wb_clk_i) begin : rx_proc
        logic [15:0] word;
        word = {rx_sh[14:0], i2s_sd_o};
        if (!rx_on) begin
            rx_sh      <= '0;
            rx_ws_prev <= 1'b0;
            rx_started <= 1'b0;
            rx_idx     <= 0;
        end else if (sck_rise) begin
            rx_sh      <= word;
            rx_ws_prev <= i2s_ws_o;
            if (i2s_ws_o != rx_ws_prev) begin
                if (!rx_started && rx_ws_prev != cfg_lswap) begin
                    compare_value("i2s_sd_o idle slot", DATA_W'(word), '0);
                end else if (exp_q.size() > 0) begin
                    compare_value("i2s_sd_o word", DATA_W'(word), DATA_W'(exp_q.pop_front()));
                    compare_value("i2s_ws_o slot", DATA_W'(rx_ws_prev),
                                  DATA_W'(cfg_lswap ^ rx_idx[0]));
                    rx_started <= 1'b1;
                    rx_idx     <= rx_idx + 1;
                    rx_total   <= rx_total + 1;
                end else begin
                    compare_value("i2s_sd_o after drain", DATA_W'(word), '0);
                end
            end
        end
    end

    a_sck_level: assert property (@(posedge wb_clk_i) disable iff (!shape_on)
        (sck_chg && sck_edges > 0) |-> (sck_run == RATIO))
        else begin
            errors++;
            $display("MISMATCH sck_level_cycles: got %h expected %h", $sampled(sck_run), RATIO);
        end

    a_ws_slot: assert property (@(posedge wb_clk_i) disable iff (!shape_on)
        ws_chg |-> (ws_rises == RES))
        else begin
            errors++;
            $display("MISMATCH ws_slot_periods: got %h expected %h", $sampled(ws_rises), RES);
        end

    a_ws_on_fall: assert property (@(posedge wb_clk_i) disable iff (!shape_on)
        ws_chg |-> sck_fall)
        else begin
            errors++;
            $display("WS changed away from an SCK falling edge");
        end

    a_stall: assert property (@(posedge wb_clk_i) stall_probe |-> !wb_ack_o)
        else begin
            errors++;
            $display("Write to TXDATA was acked while the FIFO was full");
        end

    always @(posedge wb_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        wb_rst_i = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (8) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;
        @(posedge wb_clk_i);

        compare_value("wb_ack_o", DATA_W'(wb_ack_o), '0);
        compare_value("irq_o", DATA_W'(irq_o), '0);
        compare_value("i2s_sck_o", DATA_W'(i2s_sck_o), '0);
        compare_value("i2s_ws_o", DATA_W'(i2s_ws_o), '0);
        compare_value("i2s_sd_o", DATA_W'(i2s_sd_o), '0);
        read_reg(REG_CTRL, rd_val);
        compare_value("ctrl reset", rd_val, '0);
        read_reg(REG_INTMASK, rd_val);
        compare_value("intmask reset", rd_val, '0);
        read_reg(REG_INTSTAT, rd_val);
        compare_value("intstat reset", rd_val, '0);
        read_reg(REG_STATUS, rd_val);
        compare_value("status reset", rd_val, 32'h1);

        // Unused bits read back as zero
        write_reg(REG_CTRL, 32'hFFAB_EA06);
        read_reg(REG_CTRL, rd_val);
        compare_value("ctrl", rd_val, 32'h00AB_2A06);
        write_reg(REG_INTMASK, 32'hFFFF_FFFE);
        read_reg(REG_INTMASK, rd_val);
        compare_value("intmask", rd_val, 32'h2);
        write_reg(REG_INTMASK, '0);
        write_reg(REG_CTRL, '0);

        // Fill the FIFO with the link off
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            send_word(draw_word());
            compare_value("txdata ack cycles", DATA_W'(ack_wait), DATA_W'(2));
        end
        read_reg(REG_STATUS, rd_val);
        compare_value("status full", rd_val, DATA_W'((FIFO_DEPTH << 8) | 2));

        held_word = draw_word();
        @(posedge wb_clk_i);
        wb_cyc_i    <= 1'b1;
        wb_stb_i    <= 1'b1;
        wb_we_i     <= 1'b1;
        wb_adr_i    <= REG_TXDATA;
        wb_dat_i    <= DATA_W'(held_word);
        stall_probe <= 1'b1;
        repeat (24) @(posedge wb_clk_i);
        stall_probe <= 1'b0;
        wb_cyc_i    <= 1'b0;
        wb_stb_i    <= 1'b0;
        wb_we_i     <= 1'b0;

        cfg_lswap <= 1'b0;
        rx_on     <= 1'b1;
        shape_on  <= 1'b1;
        write_reg(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0));
        send_word(held_word);
        for (int i = FIFO_DEPTH + 1; i < N_MAIN; i++) begin
            send_word(draw_word());
        end
        while (rx_total < N_MAIN) begin
            @(posedge wb_clk_i);
        end
        read_reg(REG_STATUS, rd_val);
        compare_value("status drained", rd_val, 32'h1);
        shape_on <= 1'b0;
        rx_on    <= 1'b0;
        write_reg(REG_CTRL, '0);

        // Swapped channels, interrupts armed; level above half depth first
        for (int i = 0; i < N_SWAP; i++) begin
            send_word(draw_word());
        end
        cfg_lswap <= 1'b1;
        rx_on     <= 1'b1;
        shape_on  <= 1'b1;
        write_reg(REG_CTRL, ctrl_value(1'b1, 1'b1, 1'b1));
        while (rx_total < N_MAIN + N_SWAP) begin
            @(posedge wb_clk_i);
        end

        read_reg(REG_INTSTAT, rd_val);
        compare_value("intstat", rd_val, 32'h3);
        compare_value("irq_o masked", DATA_W'(irq_o), '0);
        write_reg(REG_INTMASK, 32'h2);
        compare_value("irq_o empty", DATA_W'(irq_o), DATA_W'(1));
        write_reg(REG_INTSTAT, 32'h2);
        compare_value("irq_o cleared", DATA_W'(irq_o), '0);
        read_reg(REG_INTSTAT, rd_val);
        compare_value("intstat half", rd_val, 32'h1);
        write_reg(REG_INTMASK, 32'h1);
        compare_value("irq_o half", DATA_W'(irq_o), DATA_W'(1));
        write_reg(REG_INTSTAT, 32'h1);
        compare_value("irq_o all clear", DATA_W'(irq_o), '0);
        read_reg(REG_INTSTAT, rd_val);
        compare_value("intstat clear", rd_val, '0);

        $display("Checks finished: %0d errors, %0d words received", errors, rx_total);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
